//--- cx4_map_pkg.sv
`default_nettype none

package cx4_map_pkg;

  typedef logic [7:0]  byte_t;       // one host or bus data byte
  typedef logic [12:0] host_addr_t;  // 8 kB register window

  ////////////////////////////////////////
  // window regions
  ////////////////////////////////////////
  localparam logic [11:0] DATRAM_LIMIT = 12'hc00;  // first address past data RAM
  localparam logic [7:0]  MMIO_PAGE    = 8'hfa;    // 0x1f40..0x1f5f
  localparam logic [7:0]  VECTOR_PAGE  = 8'hfb;    // 0x1f60..0x1f7f
  localparam logic [4:0]  STATUS_FIRST = 5'h13;    // status from 0x1f53 up

  ////////////////////////////////////////
  // mmio offsets within the page
  ////////////////////////////////////////
  localparam logic [4:0] REG_DMASRC_L = 5'h00;
  localparam logic [4:0] REG_DMASRC_M = 5'h01;
  localparam logic [4:0] REG_DMASRC_H = 5'h02;
  localparam logic [4:0] REG_DMALEN_L = 5'h03;
  localparam logic [4:0] REG_DMALEN_H = 5'h04;
  localparam logic [4:0] REG_DMATGT_L = 5'h05;
  localparam logic [4:0] REG_DMATGT_M = 5'h06;
  localparam logic [4:0] REG_DMATGT_H = 5'h07;  // write here kicks the DMA
  localparam logic [4:0] REG_CFG0     = 5'h10;
  localparam logic [4:0] REG_CFG1     = 5'h11;
  localparam logic [4:0] REG_CFG2     = 5'h12;

  localparam byte_t CFG0_MASK  = 8'h77;  // bits 3 and 7 not stored
  localparam byte_t CFG0_RESET = 8'h33;
  localparam logic  CFG1_RESET = 1'b0;
  localparam logic  CFG2_RESET = 1'b1;

  localparam int STATUS_ACTIVE_BIT = 6;
  localparam int STATUS_IDLE_BIT   = 1;

  localparam byte_t UNMAPPED_BYTE = 8'hff;  // page / pc slots of the dropped cache

endpackage

`default_nettype wire

//--- cx4_bus_pkg.sv
`default_nettype none

package cx4_bus_pkg;

  typedef logic [23:0] bus_addr_t;  // external bus address
  typedef logic [15:0] dma_len_t;   // 0 stands for 65536 bytes

  // one-hot DMA sequencer states
  typedef enum logic [3:0] {
    IDLE  = 4'b0001,
    START = 4'b0010,
    WAIT  = 4'b0100,
    STEP  = 4'b1000
  } dma_state_t;

  ////////////////////////////////////////
  // source address mapping
  ////////////////////////////////////////
  // the bank byte moves down one bit so the
  // 32 kB halves of each bank pack together
  localparam int MAP_DROP_BIT = 15;

  localparam bus_addr_t MAP_LOW_MASK =
    (bus_addr_t'(1) << MAP_DROP_BIT) - bus_addr_t'(1);  // bits kept in place

endpackage

`default_nettype wire

//--- cx4_dma_if.sv
`default_nettype none

interface cx4_dma_if
  import cx4_bus_pkg::*;
();

  bus_addr_t src;    // source, before mapping
  dma_len_t  len;    // byte count
  bus_addr_t tgt;    // data RAM target, low bits used
  logic      start;  // one cycle after the target high byte write
  logic      busy;   // engine out of IDLE

  modport regs (
    output src,
    output len,
    output tgt,
    output start,
    input  busy
  );

  modport dma (
    input  src,
    input  len,
    input  tgt,
    input  start,
    output busy
  );

endinterface

`default_nettype wire

//--- cx4_datram.sv
`default_nettype none

module cx4_datram
  import cx4_map_pkg::*;
#(
  parameter int DATRAM_AW = 12
) (
  input  logic                 CLK,
  input  logic                 a_we,
  input  logic [DATRAM_AW-1:0] a_addr,
  input  byte_t                a_di,
  output byte_t                a_do,
  input  logic                 b_we,
  input  logic [DATRAM_AW-1:0] b_addr,
  input  byte_t                b_di
);

  byte_t mem [0:(2**DATRAM_AW)-1];

  // host port with registered read
  // dma port write only, last assignment wins on a clash
  always_ff @(posedge CLK) begin
    if (a_we) begin
      mem[a_addr] <= a_di;
    end
    if (b_we) begin
      mem[b_addr] <= b_di;
    end
    a_do <= mem[a_addr];  // old data on same-cycle write
  end

endmodule

`default_nettype wire

//--- cx4_dma.sv
`default_nettype none

module cx4_dma
  import cx4_map_pkg::*;
  import cx4_bus_pkg::*;
#(
  parameter int DATRAM_AW = 12
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  byte_t                BUS_DI,
  input  logic                 BUS_RDY,
  output bus_addr_t            BUS_ADDR,
  output logic                 BUS_RRQ,
  output logic                 ram_we,
  output logic [DATRAM_AW-1:0] ram_addr,
  output byte_t                ram_di,
  cx4_dma_if.dma               dma
);

  dma_state_t           state_q;
  logic                 rrq_q;
  logic                 we_q;
  bus_addr_t            src_q;
  logic [DATRAM_AW-1:0] tgt_q;
  dma_len_t             count_q;
  byte_t                data_q;

  // drop MAP_DROP_BIT and close the gap
  function automatic bus_addr_t map_addr(input bus_addr_t a);
    bus_addr_t hi;
    hi = (a >> (MAP_DROP_BIT + 1)) << MAP_DROP_BIT;
    return hi | (a & MAP_LOW_MASK);
  endfunction

  ////////////////////////////////////////
  // transfer sequencer
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state_q <= IDLE;
      rrq_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (dma.start) begin
            state_q <= START;
          end
        end
        START: begin
          src_q   <= dma.src;
          tgt_q   <= dma.tgt[DATRAM_AW-1:0];
          count_q <= dma.len;
          rrq_q   <= 1'b1;  // first byte request
          state_q <= WAIT;
        end
        WAIT: begin
          rrq_q <= 1'b0;
          if (!rrq_q && BUS_RDY) begin
            data_q  <= BUS_DI;  // take cycle
            we_q    <= 1'b1;
            count_q <= count_q - dma_len_t'(1);
            state_q <= STEP;
          end
        end
        STEP: begin
          we_q  <= 1'b0;
          src_q <= src_q + bus_addr_t'(1);
          tgt_q <= tgt_q + DATRAM_AW'(1);  // wraps inside data RAM
          if (count_q == '0) begin
            state_q <= IDLE;
          end else begin
            rrq_q   <= 1'b1;
            state_q <= WAIT;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign BUS_ADDR = map_addr(src_q);
  assign BUS_RRQ  = rrq_q;
  assign ram_we   = we_q;
  assign ram_addr = tgt_q;
  assign ram_di   = data_q;
  assign dma.busy = (state_q != IDLE);

endmodule

`default_nettype wire

//--- cx4_host_regs.sv
`default_nettype none

module cx4_host_regs
  import cx4_map_pkg::*;
  import cx4_bus_pkg::*;
#(
  parameter int DATRAM_AW = 12
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  byte_t                DI,
  input  host_addr_t           ADDR,
  input  logic                 CS,
  input  logic                 reg_we_rising,
  input  logic                 SNES_VECT_EN,
  input  byte_t                ram_do,
  output byte_t                DO,
  output logic                 ram_we,
  output logic [DATRAM_AW-1:0] ram_addr,
  cx4_dma_if.regs              dma
);

  logic [4:0] reg_off;
  logic       datram_en;
  logic       mmio_en;
  logic       status_en;
  logic       vector_en;
  logic       mmio_we;
  logic       vector_we;

  bus_addr_t  src_q;
  dma_len_t   len_q;
  bus_addr_t  tgt_q;
  byte_t      cfg0_q;
  logic       cfg1_q;
  logic       cfg2_q;
  logic       start_q;
  byte_t      vector_q [0:31];

  byte_t      mmio_rd;
  byte_t      status_rd;
  byte_t      rd_q;
  logic       ram_sel_q;

  ////////////////////////////////////////
  // region decode
  ////////////////////////////////////////
  assign reg_off   = ADDR[4:0];
  assign datram_en = CS & ~ADDR[12] & (ADDR[11:0] < DATRAM_LIMIT);
  assign mmio_en   = CS & (ADDR[12:5] == MMIO_PAGE) & (reg_off < STATUS_FIRST);
  assign status_en = CS & (ADDR[12:5] == MMIO_PAGE) & (reg_off >= STATUS_FIRST);
  // vectors also answer the cpu vector fetch while the core runs
  assign vector_en = (CS & (ADDR[12:5] == VECTOR_PAGE)) | (dma.busy & SNES_VECT_EN);

  assign mmio_we   = mmio_en & reg_we_rising;
  assign vector_we = vector_en & reg_we_rising;
  assign ram_we    = datram_en & reg_we_rising;
  assign ram_addr  = DATRAM_AW'(ADDR);

  ////////////////////////////////////////
  // mmio writes
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cfg0_q  <= CFG0_RESET;
      cfg1_q  <= CFG1_RESET;
      cfg2_q  <= CFG2_RESET;
      start_q <= 1'b0;
    end else begin
      start_q <= mmio_we & (reg_off == REG_DMATGT_H);  // single pulse
      if (mmio_we) begin
        case (reg_off)
          REG_CFG0: cfg0_q <= DI & CFG0_MASK;
          REG_CFG1: cfg1_q <= DI[0];
          REG_CFG2: cfg2_q <= DI[0];
          default:  ;
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (mmio_we) begin
      case (reg_off)
        REG_DMASRC_L: src_q[7:0]   <= DI;
        REG_DMASRC_M: src_q[15:8]  <= DI;
        REG_DMASRC_H: src_q[23:16] <= DI;
        REG_DMALEN_L: len_q[7:0]   <= DI;
        REG_DMALEN_H: len_q[15:8]  <= DI;
        REG_DMATGT_L: tgt_q[7:0]   <= DI;
        REG_DMATGT_M: tgt_q[15:8]  <= DI;
        REG_DMATGT_H: tgt_q[23:16] <= DI;
        default:      ;  // 0x1f48..0x1f4f dropped
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (vector_we) begin
      vector_q[reg_off] <= DI;
    end
  end

  assign dma.src   = src_q;
  assign dma.len   = len_q;
  assign dma.tgt   = tgt_q;
  assign dma.start = start_q;

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////
  always_comb begin
    case (reg_off)
      REG_DMASRC_L: mmio_rd = src_q[7:0];
      REG_DMASRC_M: mmio_rd = src_q[15:8];
      REG_DMASRC_H: mmio_rd = src_q[23:16];
      REG_DMALEN_L: mmio_rd = len_q[7:0];
      REG_DMALEN_H: mmio_rd = len_q[15:8];
      REG_DMATGT_L: mmio_rd = tgt_q[7:0];
      REG_DMATGT_M: mmio_rd = tgt_q[15:8];
      REG_DMATGT_H: mmio_rd = tgt_q[23:16];
      REG_CFG0:     mmio_rd = cfg0_q;
      REG_CFG1:     mmio_rd = {7'b0, cfg1_q};
      REG_CFG2:     mmio_rd = {7'b0, cfg2_q};
      default:      mmio_rd = UNMAPPED_BYTE;
    endcase
  end

  always_comb begin
    status_rd = '0;
    status_rd[STATUS_ACTIVE_BIT] = dma.busy;
    status_rd[STATUS_IDLE_BIT]   = ~dma.busy;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ram_sel_q <= 1'b0;
      rd_q      <= '0;
    end else begin
      ram_sel_q <= datram_en;  // ram data shows up next cycle
      if (mmio_en) begin
        rd_q <= mmio_rd;
      end else if (status_en) begin
        rd_q <= status_rd;
      end else if (vector_en) begin
        rd_q <= vector_q[reg_off];
      end else begin
        rd_q <= '0;  // open space reads zero
      end
    end
  end

  assign DO = ram_sel_q ? ram_do : rd_q;

endmodule

`default_nettype wire

//--- cx4_top.sv
`default_nettype none

module cx4_top
  import cx4_map_pkg::*;
  import cx4_bus_pkg::*;
#(
  parameter int DATRAM_AW = 12
) (
  input  logic       CLK,
  input  logic       rst_n,
  input  byte_t      DI,
  output byte_t      DO,
  input  host_addr_t ADDR,
  input  logic       CS,
  input  logic       reg_we_rising,
  input  logic       SNES_VECT_EN,
  input  byte_t      BUS_DI,
  output bus_addr_t  BUS_ADDR,
  output logic       BUS_RRQ,
  input  logic       BUS_RDY,
  output logic       cx4_active
);

  logic                 host_ram_we;
  logic [DATRAM_AW-1:0] host_ram_addr;
  byte_t                host_ram_do;
  logic                 dma_ram_we;
  logic [DATRAM_AW-1:0] dma_ram_addr;
  byte_t                dma_ram_di;

  cx4_dma_if dma_if ();

  ////////////////////////////////////////
  // host side
  ////////////////////////////////////////
  cx4_host_regs #(
    .DATRAM_AW (DATRAM_AW)
  ) host_regs_inst (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .DI            (DI),
    .ADDR          (ADDR),
    .CS            (CS),
    .reg_we_rising (reg_we_rising),
    .SNES_VECT_EN  (SNES_VECT_EN),
    .ram_do        (host_ram_do),
    .DO            (DO),
    .ram_we        (host_ram_we),
    .ram_addr      (host_ram_addr),
    .dma           (dma_if.regs)
  );

  ////////////////////////////////////////
  // transfer side
  ////////////////////////////////////////
  cx4_dma #(
    .DATRAM_AW (DATRAM_AW)
  ) dma_inst (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .BUS_DI   (BUS_DI),
    .BUS_RDY  (BUS_RDY),
    .BUS_ADDR (BUS_ADDR),
    .BUS_RRQ  (BUS_RRQ),
    .ram_we   (dma_ram_we),
    .ram_addr (dma_ram_addr),
    .ram_di   (dma_ram_di),
    .dma      (dma_if.dma)
  );

  cx4_datram #(
    .DATRAM_AW (DATRAM_AW)
  ) datram_inst (
    .CLK    (CLK),
    .a_we   (host_ram_we),
    .a_addr (host_ram_addr),
    .a_di   (DI),
    .a_do   (host_ram_do),
    .b_we   (dma_ram_we),
    .b_addr (dma_ram_addr),
    .b_di   (dma_ram_di)
  );

  assign cx4_active = dma_if.busy;  // only the dma keeps the core busy

endmodule

`default_nettype wire

//--- tb_cx4.sv
`default_nettype none

module tb_cx4
  import cx4_map_pkg::*;
  import cx4_bus_pkg::*;
();

  typedef enum {ACT_WRITE, ACT_READ, ACT_BUSY, ACT_IDLE} act_t;

  typedef struct {
    string      name;
    act_t       act;
    host_addr_t addr;
    byte_t      data;
    byte_t      exp_val;
    logic       vect;  // SNES_VECT_EN during a read
  } step_t;

  logic       CLK           = 1'b0;
  logic       rst_n         = 1'b0;
  byte_t      DI            = '0;
  byte_t      DO;
  host_addr_t ADDR          = '0;
  logic       CS            = 1'b0;
  logic       reg_we_rising = 1'b0;
  logic       SNES_VECT_EN  = 1'b0;
  byte_t      BUS_DI        = '0;
  bus_addr_t  BUS_ADDR;
  logic       BUS_RRQ;
  logic       BUS_RDY       = 1'b0;
  logic       cx4_active;

  step_t      steps [$];
  bus_addr_t  req_log [$];     // every address the bus model served
  int         log_base     = 0;
  bus_addr_t  dma_src      = '0;  // source as programmed by the host
  dma_len_t   dma_len      = '0;
  int         dma_bytes    = 0;
  int         limit_cycles = 0;
  int         errors       = 0;
  int         bus_errors   = 0;
  int         checks       = 0;
  int         seed         = 32'h185e9819;
  int         rdy_wait     = 0;
  logic       serving      = 1'b0;

  always #5 CLK = ~CLK;

  cx4_top #(
    .DATRAM_AW (12)
  ) cx4_top_inst (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .DI            (DI),
    .DO            (DO),
    .ADDR          (ADDR),
    .CS            (CS),
    .reg_we_rising (reg_we_rising),
    .SNES_VECT_EN  (SNES_VECT_EN),
    .BUS_DI        (BUS_DI),
    .BUS_ADDR      (BUS_ADDR),
    .BUS_RRQ       (BUS_RRQ),
    .BUS_RDY       (BUS_RDY),
    .cx4_active    (cx4_active)
  );

  // cart side address, bit 15 squeezed out
  function automatic bus_addr_t mapped(input bus_addr_t a);
    return {1'b0, a[23:16], a[14:0]};
  endfunction

  ////////////////////////////////////////
  // external bus model
  ////////////////////////////////////////
  always @(posedge CLK) begin
    if (!rst_n) begin
      BUS_RDY <= 1'b0;
      serving = 1'b0;
    end else begin
      if (BUS_RDY) begin
        BUS_RDY <= 1'b0;  // ready lasts one cycle
      end
      if (BUS_RRQ) begin
        assert (!serving && !BUS_RDY) else begin
          bus_errors++;
          $display("unexpected bus request at %06h while a byte is still pending", BUS_ADDR);
        end
        req_log.push_back(BUS_ADDR);
        serving  = 1'b1;
        rdy_wait = $unsigned($random(seed)) % 5;
      end
      if (serving) begin
        if (rdy_wait == 0) begin
          BUS_RDY <= 1'b1;
          BUS_DI  <= BUS_ADDR[7:0] ^ BUS_ADDR[15:8];
          serving = 1'b0;
        end else begin
          rdy_wait--;
        end
      end
    end
  end

  function automatic void add_step(input string name, input act_t act, input host_addr_t addr,
                                   input byte_t data, input byte_t exp_val, input logic vect);
    step_t s;
    s = '{name, act, addr, data, exp_val, vect};
    steps.push_back(s);
    if (act == ACT_WRITE && addr == 13'h1f43) dma_bytes += int'(data);
    if (act == ACT_WRITE && addr == 13'h1f44) dma_bytes += 256 * int'(data);
  endfunction

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////
  function automatic void fill_table();
    add_step("cfg0_reset",   ACT_READ,  13'h1f50, 8'h00, 8'h33, 1'b0);
    add_step("cfg1_reset",   ACT_READ,  13'h1f51, 8'h00, 8'h00, 1'b0);
    add_step("cfg2_reset",   ACT_READ,  13'h1f52, 8'h00, 8'h01, 1'b0);
    add_step("status_idle",  ACT_READ,  13'h1f53, 8'h00, 8'h02, 1'b0);
    add_step("status_top",   ACT_READ,  13'h1f5f, 8'h00, 8'h02, 1'b0);
    add_step("page_48",      ACT_READ,  13'h1f48, 8'h00, 8'hff, 1'b0);
    add_step("page_4a_wr",   ACT_WRITE, 13'h1f4a, 8'h12, 8'h00, 1'b0);
    add_step("page_4a",      ACT_READ,  13'h1f4a, 8'h00, 8'hff, 1'b0);
    add_step("page_4f",      ACT_READ,  13'h1f4f, 8'h00, 8'hff, 1'b0);
    add_step("cfg0_wr_ff",   ACT_WRITE, 13'h1f50, 8'hff, 8'h00, 1'b0);
    add_step("cfg0_mask_ff", ACT_READ,  13'h1f50, 8'h00, 8'h77, 1'b0);
    add_step("cfg0_wr_5a",   ACT_WRITE, 13'h1f50, 8'h5a, 8'h00, 1'b0);
    add_step("cfg0_mask_5a", ACT_READ,  13'h1f50, 8'h00, 8'h52, 1'b0);
    add_step("cfg1_wr",      ACT_WRITE, 13'h1f51, 8'h01, 8'h00, 1'b0);
    add_step("cfg1",         ACT_READ,  13'h1f51, 8'h00, 8'h01, 1'b0);
    // data RAM edges and open space
    add_step("ram_000_wr",   ACT_WRITE, 13'h0000, 8'ha5, 8'h00, 1'b0);
    add_step("ram_3ff_wr",   ACT_WRITE, 13'h03ff, 8'h5c, 8'h00, 1'b0);
    add_step("ram_bff_wr",   ACT_WRITE, 13'h0bff, 8'h96, 8'h00, 1'b0);
    add_step("ram_000",      ACT_READ,  13'h0000, 8'h00, 8'ha5, 1'b0);
    add_step("ram_3ff",      ACT_READ,  13'h03ff, 8'h00, 8'h5c, 1'b0);
    add_step("ram_bff",      ACT_READ,  13'h0bff, 8'h00, 8'h96, 1'b0);
    add_step("open_c10_wr",  ACT_WRITE, 13'h0c10, 8'h77, 8'h00, 1'b0);
    add_step("open_c10",     ACT_READ,  13'h0c10, 8'h00, 8'h00, 1'b0);
    add_step("open_1000_wr", ACT_WRITE, 13'h1000, 8'h3c, 8'h00, 1'b0);
    add_step("open_1000",    ACT_READ,  13'h1000, 8'h00, 8'h00, 1'b0);
    add_step("ram_000_kept", ACT_READ,  13'h0000, 8'h00, 8'ha5, 1'b0);
    add_step("vec_60_wr",    ACT_WRITE, 13'h1f60, 8'h11, 8'h00, 1'b0);
    add_step("vec_65_wr",    ACT_WRITE, 13'h1f65, 8'hc3, 8'h00, 1'b0);
    add_step("vec_7f_wr",    ACT_WRITE, 13'h1f7f, 8'he8, 8'h00, 1'b0);
    add_step("vec_60",       ACT_READ,  13'h1f60, 8'h00, 8'h11, 1'b0);
    add_step("vec_65",       ACT_READ,  13'h1f65, 8'h00, 8'hc3, 1'b0);
    add_step("vec_7f",       ACT_READ,  13'h1f7f, 8'h00, 8'he8, 1'b0);
    // first transfer, 5 bytes from 0x128040
    add_step("src_l_wr",     ACT_WRITE, 13'h1f40, 8'h40, 8'h00, 1'b0);
    add_step("src_m_wr",     ACT_WRITE, 13'h1f41, 8'h80, 8'h00, 1'b0);
    add_step("src_h_wr",     ACT_WRITE, 13'h1f42, 8'h12, 8'h00, 1'b0);
    add_step("len_l_wr",     ACT_WRITE, 13'h1f43, 8'h05, 8'h00, 1'b0);
    add_step("len_h_wr",     ACT_WRITE, 13'h1f44, 8'h00, 8'h00, 1'b0);
    add_step("tgt_l_wr",     ACT_WRITE, 13'h1f45, 8'h10, 8'h00, 1'b0);
    add_step("tgt_m_wr",     ACT_WRITE, 13'h1f46, 8'h00, 8'h00, 1'b0);
    add_step("src_l",        ACT_READ,  13'h1f40, 8'h00, 8'h40, 1'b0);
    add_step("src_m",        ACT_READ,  13'h1f41, 8'h00, 8'h80, 1'b0);
    add_step("src_h",        ACT_READ,  13'h1f42, 8'h00, 8'h12, 1'b0);
    add_step("len_l",        ACT_READ,  13'h1f43, 8'h00, 8'h05, 1'b0);
    add_step("tgt_l",        ACT_READ,  13'h1f45, 8'h00, 8'h10, 1'b0);
    add_step("dma1_start",   ACT_WRITE, 13'h1f47, 8'h00, 8'h00, 1'b0);
    add_step("dma1_busy",    ACT_BUSY,  13'h0000, 8'h00, 8'h00, 1'b0);
    add_step("status_busy",  ACT_READ,  13'h1f53, 8'h00, 8'h40, 1'b0);
    add_step("vect_outside", ACT_READ,  13'h1c05, 8'h00, 8'hc3, 1'b1);
    add_step("dma1_done",    ACT_IDLE,  13'h0000, 8'h00, 8'h00, 1'b0);
    add_step("status_after", ACT_READ,  13'h1f53, 8'h00, 8'h02, 1'b0);
    add_step("dma1_010",     ACT_READ,  13'h0010, 8'h00, 8'h40, 1'b0);
    add_step("dma1_011",     ACT_READ,  13'h0011, 8'h00, 8'h41, 1'b0);
    add_step("dma1_012",     ACT_READ,  13'h0012, 8'h00, 8'h42, 1'b0);
    add_step("dma1_013",     ACT_READ,  13'h0013, 8'h00, 8'h43, 1'b0);
    add_step("dma1_014",     ACT_READ,  13'h0014, 8'h00, 8'h44, 1'b0);
    // second transfer crosses 0x7fff, mapped data 81 80 00 01
    add_step("src2_l_wr",    ACT_WRITE, 13'h1f40, 8'hfe, 8'h00, 1'b0);
    add_step("src2_m_wr",    ACT_WRITE, 13'h1f41, 8'h7f, 8'h00, 1'b0);
    add_step("src2_h_wr",    ACT_WRITE, 13'h1f42, 8'h0a, 8'h00, 1'b0);
    add_step("len2_l_wr",    ACT_WRITE, 13'h1f43, 8'h04, 8'h00, 1'b0);
    add_step("tgt2_l_wr",    ACT_WRITE, 13'h1f45, 8'h20, 8'h00, 1'b0);
    add_step("dma2_start",   ACT_WRITE, 13'h1f47, 8'h00, 8'h00, 1'b0);
    add_step("dma2_busy",    ACT_BUSY,  13'h0000, 8'h00, 8'h00, 1'b0);
    add_step("dma2_done",    ACT_IDLE,  13'h0000, 8'h00, 8'h00, 1'b0);
    add_step("dma2_020",     ACT_READ,  13'h0020, 8'h00, 8'h81, 1'b0);
    add_step("dma2_021",     ACT_READ,  13'h0021, 8'h00, 8'h80, 1'b0);
    add_step("dma2_022",     ACT_READ,  13'h0022, 8'h00, 8'h00, 1'b0);
    add_step("dma2_023",     ACT_READ,  13'h0023, 8'h00, 8'h01, 1'b0);
  endfunction

  task automatic run_step(input step_t s);
    int n;
    int exp_count;
    int got_count;
    int k;
    case (s.act)
      ACT_WRITE: begin
        @(posedge CLK);
        CS            <= 1'b1;
        ADDR          <= s.addr;
        DI            <= s.data;
        reg_we_rising <= 1'b1;
        @(posedge CLK);
        CS            <= 1'b0;
        reg_we_rising <= 1'b0;
        case (s.addr)  // keep a copy of the DMA setup
          13'h1f40: dma_src[7:0]   = s.data;
          13'h1f41: dma_src[15:8]  = s.data;
          13'h1f42: dma_src[23:16] = s.data;
          13'h1f43: dma_len[7:0]   = s.data;
          13'h1f44: dma_len[15:8]  = s.data;
          default:  ;
        endcase
      end
      ACT_READ: begin
        @(posedge CLK);
        CS           <= 1'b1;
        ADDR         <= s.addr;
        SNES_VECT_EN <= s.vect;
        @(posedge CLK);
        CS           <= 1'b0;
        SNES_VECT_EN <= 1'b0;
        @(negedge CLK);  // DO registered one cycle after the address
        checks++;
        assert (DO === s.exp_val) else begin
          errors++;
          $display("Mismatch %s: expected %02h, actual %02h", s.name, s.exp_val, DO);
        end
      end
      ACT_BUSY: begin
        n = 0;
        while (cx4_active !== 1'b1 && n < 20) begin
          @(negedge CLK);
          n++;
        end
        checks++;
        assert (cx4_active === 1'b1) else begin
          errors++;
          $display("%s: cx4_active did not rise after the DMA start", s.name);
        end
      end
      ACT_IDLE: begin
        exp_count = (dma_len == '0) ? 65536 : int'(dma_len);
        n = 0;
        while (cx4_active !== 1'b0 && n < 200 + 8 * exp_count) begin
          @(negedge CLK);
          n++;
        end
        checks++;
        assert (cx4_active === 1'b0) else begin
          errors++;
          $display("%s: cx4_active stayed high, transfer never finished", s.name);
        end
        got_count = req_log.size() - log_base;
        assert (got_count == exp_count) else begin
          errors++;
          $display("%s: %0d bus requests seen for a length of %0d", s.name, got_count, exp_count);
        end
        for (k = 0; k < got_count && k < exp_count; k++) begin
          assert (req_log[log_base + k] === mapped(dma_src + bus_addr_t'(k))) else begin
            errors++;
            $display("Mismatch %s: expected %06h, actual %06h", s.name,
                     mapped(dma_src + bus_addr_t'(k)), req_log[log_base + k]);
          end
        end
        log_base = req_log.size();
      end
      default: ;
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////
  initial begin
    int total;
    fill_table();
    limit_cycles = steps.size() * 200 + dma_bytes * 8;
    repeat (3) @(posedge CLK);
    rst_n <= 1'b1;
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    @(posedge CLK);
    total = errors + bus_errors;
    $display("checks %0d, errors %0d", checks, total);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge CLK);
    $display("watchdog expired after %0d cycles, run did not complete", limit_cycles);
    $display("checks %0d, errors %0d", checks, errors + bus_errors + 1);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
cx4_map_pkg.sv
cx4_bus_pkg.sv
cx4_dma_if.sv
cx4_datram.sv
cx4_dma.sv
cx4_host_regs.sv
cx4_top.sv
tb_cx4.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cx4 testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_cx4 -o tb_cx4
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_cx4 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$log"; then
  exit 1
fi
exit 0
